// ==== rtl/rv_pkg.sv ====
package rv_pkg;

  // datapath and register file geometry
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // byte-wide instruction bus
  localparam int FETCH_BYTES      = 4;  // bytes per instruction word
  localparam int MEM_READ_LATENCY = 2;  // address to data, in enabled cycles

  // major opcodes handled by this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 encodings shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;  // ADD, SUB, ADDI
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // SRL and SRA
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 encodings
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // selects SUB and SRA

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // LUI, result is operand b
  } alu_op_e;

  // IF to ID, valid is a one-cycle strobe
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] instr;
  } fetch_t;

  // ID/EX register contents
  typedef struct packed {
    logic                  valid;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
  } exec_t;

  // EX/WB record, also the retire output
  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       value;
  } retire_t;

endpackage

// ==== rtl/reg_file.sv ====
module reg_file (
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  logic                          rdy_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
  input  rv_pkg::retire_t               wb_i
);

  logic [rv_pkg::XLEN-1:0] regs_q [2**rv_pkg::REG_ADDR_W];

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    else if (rdy_i && wb_i.valid && wb_i.rd != '0)
    begin
      regs_q[wb_i.rd] <= wb_i.value;
    end
  end

  // x0 is hardwired, never trust the array entry
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// ==== rtl/fetch_unit.sv ====
module fetch_unit (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   rdy_i,
  input  logic [7:0]             mem_din_i,
  output logic [31:0]            mem_a_o,
  output rv_pkg::fetch_t         fetch_o
);

  // byte position inside an instruction word
  typedef logic [$clog2(rv_pkg::FETCH_BYTES)-1:0] lane_t;

  logic [31:0]             addr_q;
  logic                    lane_vld_q [rv_pkg::MEM_READ_LATENCY];
  lane_t                   lane_q [rv_pkg::MEM_READ_LATENCY];
  logic [rv_pkg::XLEN-1:0] word_q;
  logic                    fetch_vld_q;
  logic [rv_pkg::XLEN-1:0] instr_q;

  logic  byte_vld;
  lane_t byte_lane;
  logic  word_done;

  // the tail of the tag pipe lines up with the byte on mem_din_i
  assign byte_vld  = lane_vld_q[rv_pkg::MEM_READ_LATENCY-1];
  assign byte_lane = lane_q[rv_pkg::MEM_READ_LATENCY-1];
  assign word_done = byte_vld && (byte_lane == lane_t'(rv_pkg::FETCH_BYTES - 1));

  assign mem_a_o       = addr_q;
  assign fetch_o.valid = fetch_vld_q;
  assign fetch_o.instr = instr_q;

  // free-running byte address, one new request per enabled cycle
  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      addr_q <= '0;
    end
    else if (rdy_i)
    begin
      addr_q <= addr_q + 32'd1;
    end
  end

  // in-flight tracking, one valid bit per outstanding read
  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      for (int i = 0; i < rv_pkg::MEM_READ_LATENCY; i++)
      begin
        lane_vld_q[i] <= 1'b0;
      end
    end
    else if (rdy_i)
    begin
      lane_vld_q[0] <= 1'b1;
      for (int i = 1; i < rv_pkg::MEM_READ_LATENCY; i++)
      begin
        lane_vld_q[i] <= lane_vld_q[i-1];
      end
    end
  end

  // low address bits travel with the request
  always_ff @(posedge clk_in)
  begin
    if (rdy_i)
    begin
      lane_q[0] <= lane_t'(addr_q);
      for (int i = 1; i < rv_pkg::MEM_READ_LATENCY; i++)
      begin
        lane_q[i] <= lane_q[i-1];
      end
    end
  end

  // little-endian assembly, the last byte goes straight into instr_q
  always_ff @(posedge clk_in)
  begin
    if (rdy_i)
    begin
      if (byte_vld)
      begin
        word_q[8*byte_lane +: 8] <= mem_din_i;
      end
      if (word_done)
      begin
        instr_q <= {mem_din_i, word_q[rv_pkg::XLEN-9:0]};
      end
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      fetch_vld_q <= 1'b0;
    end
    else if (rdy_i)
    begin
      fetch_vld_q <= word_done;  // single-cycle strobe
    end
  end

endmodule

// ==== rtl/decode_stage.sv ====
module decode_stage (
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  logic                          rdy_i,
  input  rv_pkg::fetch_t                fetch_i,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
  output rv_pkg::exec_t                 exec_o
);

  logic [6:0]                    opcode;
  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [rv_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_pkg::XLEN-1:0]       imm_i;
  logic [rv_pkg::XLEN-1:0]       imm_u;
  logic [rv_pkg::XLEN-1:0]       shamt;

  rv_pkg::alu_op_e         alu_op;
  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic                    known;
  rv_pkg::exec_t           exec_q;

  assign opcode = fetch_i.instr[6:0];
  assign rd     = fetch_i.instr[11:7];
  assign funct3 = fetch_i.instr[14:12];
  assign funct7 = fetch_i.instr[31:25];

  assign rs1_addr_o = fetch_i.instr[19:15];
  assign rs2_addr_o = fetch_i.instr[24:20];

  assign imm_i = {{20{fetch_i.instr[31]}}, fetch_i.instr[31:20]};
  assign imm_u = {fetch_i.instr[31:12], 12'b0};
  assign shamt = {27'b0, fetch_i.instr[24:20]};

  always_comb
  begin
    alu_op = rv_pkg::ALU_ADD;
    op_a   = rs1_data_i;
    op_b   = rs2_data_i;
    known  = 1'b0;

    // same funct3 map for OP and OP-IMM, funct7 only matters for OP and shifts
    unique case (funct3)
      rv_pkg::F3_ADD:  alu_op = (opcode == rv_pkg::OPC_OP && funct7 == rv_pkg::F7_ALT) ?
                                rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:  alu_op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:  alu_op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU: alu_op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:  alu_op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SR:   alu_op = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:   alu_op = rv_pkg::ALU_OR;
      rv_pkg::F3_AND:  alu_op = rv_pkg::ALU_AND;
    endcase

    case (opcode)
      rv_pkg::OPC_OP:
      begin
        known = (funct7 == rv_pkg::F7_BASE) ||
                (funct7 == rv_pkg::F7_ALT &&
                 (funct3 == rv_pkg::F3_ADD || funct3 == rv_pkg::F3_SR));
      end
      rv_pkg::OPC_OP_IMM:
      begin
        if (funct3 == rv_pkg::F3_SLL)
        begin
          op_b  = shamt;
          known = (funct7 == rv_pkg::F7_BASE);
        end
        else if (funct3 == rv_pkg::F3_SR)
        begin
          op_b  = shamt;
          known = (funct7 == rv_pkg::F7_BASE) || (funct7 == rv_pkg::F7_ALT);
        end
        else
        begin
          op_b  = imm_i;
          known = 1'b1;
        end
      end
      rv_pkg::OPC_LUI:
      begin
        alu_op = rv_pkg::ALU_PASS_B;
        op_a   = '0;
        op_b   = imm_u;
        known  = 1'b1;
      end
      default: known = 1'b0;  // anything else retires nothing
    endcase
  end

  // ID/EX register
  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      exec_q.valid <= 1'b0;
    end
    else if (rdy_i)
    begin
      exec_q.valid <= fetch_i.valid && known && (rd != '0);
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_i)
    begin
      exec_q.alu_op    <= alu_op;
      exec_q.operand_a <= op_a;
      exec_q.operand_b <= op_b;
      exec_q.rd        <= rd;
    end
  end

  assign exec_o = exec_q;

endmodule

// ==== rtl/execute_stage.sv ====
module execute_stage (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_i,
  input  rv_pkg::exec_t   exec_i,
  output rv_pkg::retire_t retire_o
);

  logic [rv_pkg::XLEN-1:0] a;
  logic [rv_pkg::XLEN-1:0] b;
  logic [4:0]              shamt;
  logic [rv_pkg::XLEN-1:0] result;
  rv_pkg::retire_t         retire_q;

  assign a     = exec_i.operand_a;
  assign b     = exec_i.operand_b;
  assign shamt = b[4:0];  // only the low five bits count

  always_comb
  begin
    unique case (exec_i.alu_op)
      rv_pkg::ALU_ADD:  result = a + b;
      rv_pkg::ALU_SUB:  result = a - b;
      rv_pkg::ALU_SLL:  result = a << shamt;
      rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::ALU_SLTU: result = {31'b0, a < b};
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_SRL:  result = a >> shamt;
      rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      rv_pkg::ALU_OR:   result = a | b;
      rv_pkg::ALU_AND:  result = a & b;
      default:          result = b;  // PASS_B for LUI
    endcase
  end

  // EX/WB register
  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      retire_q.valid <= 1'b0;
    end
    else if (rdy_i)
    begin
      retire_q.valid <= exec_i.valid;
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_i)
    begin
      retire_q.rd    <= exec_i.rd;
      retire_q.value <= result;
    end
  end

  assign retire_o = retire_q;

endmodule

// ==== rtl/cpu.sv ====
module cpu (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,     // freezes the whole core when low
  input  logic [7:0]      mem_din_i,
  output logic [31:0]     mem_a_o,
  output rv_pkg::retire_t retire_o
);

  rv_pkg::fetch_t                fetch;
  rv_pkg::exec_t                 exec;
  rv_pkg::retire_t               retire;
  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [rv_pkg::XLEN-1:0]       rs1_data;
  logic [rv_pkg::XLEN-1:0]       rs2_data;

  fetch_unit u_fetch (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_i     (rdy_in),
    .mem_din_i (mem_din_i),
    .mem_a_o   (mem_a_o),
    .fetch_o   (fetch)
  );

  decode_stage u_decode (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_i      (rdy_in),
    .fetch_i    (fetch),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .exec_o     (exec)
  );

  execute_stage u_execute (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .rdy_i    (rdy_in),
    .exec_i   (exec),
    .retire_o (retire)
  );

  // the retire record doubles as the write port
  reg_file u_regs (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_i      (rdy_in),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (retire)
  );

  assign retire_o = retire;

endmodule

// ==== tests/mem_model.sv ====
module mem_model #(
  parameter int ADDR_W = 10  // byte address bits actually decoded
) (
  input  logic        clk_in,
  input  logic        rdy_i,
  input  logic [31:0] addr_i,
  output logic [7:0]  data_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // byte array, filled by the testbench before the clock starts
  logic [7:0] mem_q [2**ADDR_W];
  logic [7:0] pipe_q [rv_pkg::MEM_READ_LATENCY];

  // two-stage read, frozen together with the core
  always_ff @(posedge clk_in)
  begin
    if (rdy_i)
    begin
      pipe_q[0] <= mem_q[addr_i[ADDR_W-1:0]];
      for (int i = 1; i < rv_pkg::MEM_READ_LATENCY; i++)
      begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  assign data_o = pipe_q[rv_pkg::MEM_READ_LATENCY-1];  // byte k shows up in cycle k+2

endmodule

// ==== tests/tb_cpu.sv ====
module tb_cpu #(
  parameter int MEM_ADDR_W = 10
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    logic [31:0] instr;
    string       name;
    logic [4:0]  rd;
    logic [31:0] value;
    bit          retires;
  } test_t;

  logic            clk_in;
  logic            rst_in;
  logic            rdy_in;
  logic [7:0]      mem_din;
  logic [31:0]     mem_a;
  rv_pkg::retire_t retire;

  test_t           tests[$];
  rv_pkg::retire_t seen[$];   // retire records of the current run in order
  int              cycle;     // enabled cycles since reset release
  int              err_cnt = 0;
  int              pass_cnt = 0;
  int              fail_cnt = 0;

  cpu u_dut (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .mem_din_i (mem_din),
    .mem_a_o   (mem_a),
    .retire_o  (retire)
  );

  mem_model #(.ADDR_W(MEM_ADDR_W)) u_mem (
    .clk_in (clk_in),
    .rdy_i  (rdy_in),
    .addr_i (mem_a),
    .data_o (mem_din)
  );

  initial
  begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_test(input logic [31:0] instr, input string name,
                          input logic [4:0] rd, input logic [31:0] value);
    test_t t;
    t.instr   = instr;
    t.name    = name;
    t.rd      = rd;
    t.value   = value;
    t.retires = 1'b1;
    tests.push_back(t);
  endtask

  // instruction that must not produce a retire record
  task automatic add_silent(input logic [31:0] instr, input string name);
    test_t t;
    t.instr   = instr;
    t.name    = name;
    t.rd      = '0;
    t.value   = '0;
    t.retires = 1'b0;
    tests.push_back(t);
  endtask

  // program with hand-computed results that mostly feed the next instruction
  task automatic build_table();
    add_test(enc_i(3'b000, 5'd1, 5'd0, 12'hffb), "addi x1,x0,-5", 5'd1, 32'hfffffffb);
    add_test(enc_i(3'b000, 5'd2, 5'd1, 12'h00c), "addi x2,x1,12", 5'd2, 32'h00000007);
    add_test(enc_r(3'b000, 7'h00, 5'd3, 5'd1, 5'd2), "add x3,x1,x2", 5'd3, 32'h00000002);
    add_test(enc_r(3'b000, 7'h20, 5'd4, 5'd3, 5'd1), "sub x4,x3,x1", 5'd4, 32'h00000007);
    add_test(enc_u(20'h80000, 5'd5), "lui x5,0x80000", 5'd5, 32'h80000000);
    add_test(enc_r(3'b110, 7'h00, 5'd6, 5'd5, 5'd4), "or x6,x5,x4", 5'd6, 32'h80000007);
    add_test(enc_r(3'b100, 7'h00, 5'd7, 5'd6, 5'd1), "xor x7,x6,x1", 5'd7, 32'h7ffffffc);
    add_test(enc_r(3'b111, 7'h00, 5'd8, 5'd7, 5'd6), "and x8,x7,x6", 5'd8, 32'h00000004);
    add_test(enc_i(3'b000, 5'd9, 5'd8, 12'h01f), "addi x9,x8,31", 5'd9, 32'h00000023);
    add_test(enc_r(3'b001, 7'h00, 5'd10, 5'd4, 5'd9), "sll x10,x4,x9", 5'd10, 32'h00000038);
    add_test(enc_r(3'b101, 7'h20, 5'd11, 5'd6, 5'd10), "sra x11,x6,x10", 5'd11, 32'hffffff80);
    add_test(enc_r(3'b101, 7'h00, 5'd12, 5'd11, 5'd9), "srl x12,x11,x9", 5'd12, 32'h1ffffff0);
    add_test(enc_r(3'b010, 7'h00, 5'd13, 5'd11, 5'd12), "slt x13,x11,x12", 5'd13, 32'h1);
    add_test(enc_r(3'b011, 7'h00, 5'd14, 5'd13, 5'd11), "sltu x14,x13,x11", 5'd14, 32'h1);
    add_test(enc_r(3'b011, 7'h00, 5'd15, 5'd11, 5'd14), "sltu x15,x11,x14", 5'd15, 32'h0);
    add_test(enc_i(3'b010, 5'd16, 5'd15, 12'hffc), "slti x16,x15,-4", 5'd16, 32'h0);
    add_test(enc_i(3'b011, 5'd17, 5'd16, 12'hfff), "sltiu x17,x16,-1", 5'd17, 32'h1);
    add_test(enc_i(3'b100, 5'd18, 5'd17, 12'hfff), "xori x18,x17,-1", 5'd18, 32'hfffffffe);
    add_test(enc_i(3'b111, 5'd19, 5'd18, 12'h7f0), "andi x19,x18,0x7f0", 5'd19, 32'h7f0);
    add_test(enc_i(3'b110, 5'd20, 5'd19, 12'h00f), "ori x20,x19,0xf", 5'd20, 32'h7ff);
    add_test(enc_i(3'b001, 5'd21, 5'd20, 12'h015), "slli x21,x20,21", 5'd21, 32'hffe00000);
    add_test(enc_i(3'b101, 5'd22, 5'd21, 12'h004), "srli x22,x21,4", 5'd22, 32'h0ffe0000);
    add_test(enc_i(3'b101, 5'd23, 5'd21, 12'h404), "srai x23,x21,4", 5'd23, 32'hfffe0000);
    add_test(enc_u(20'habcde, 5'd24), "lui x24,0xabcde", 5'd24, 32'habcde000);
    add_test(enc_i(3'b000, 5'd24, 5'd24, 12'h123), "addi x24,x24,0x123", 5'd24, 32'habcde123);
    add_silent(enc_r(3'b000, 7'h00, 5'd0, 5'd1, 5'd2), "add x0,x1,x2");
    add_silent(32'h0000af83, "lw x31,0(x1)");  // load opcode that the core does not decode
    add_test(enc_r(3'b000, 7'h00, 5'd25, 5'd0, 5'd24), "add x25,x0,x24", 5'd25, 32'habcde123);
    add_test(enc_r(3'b000, 7'h00, 5'd26, 5'd31, 5'd0), "add x26,x31,x0", 5'd26, 32'h0);
  endtask

  task automatic load_program();
    logic [31:0] word;
    for (int w = 0; w < 2**(MEM_ADDR_W-2); w++)
    begin
      if (w < tests.size())
      begin
        word = tests[w].instr;
      end
      else
      begin
        word = enc_i(3'b000, 5'd0, 5'd0, 12'(w));  // addi x0,x0,<word address>
      end
      for (int b = 0; b < 4; b++)
      begin
        u_mem.mem_q[4*w + b] = word[8*b +: 8];  // little endian
      end
    end
  endtask

  task automatic check_retire(input string sig, input rv_pkg::retire_t exp,
                              input rv_pkg::retire_t act);
    if (act.valid !== exp.valid || (exp.valid && (act.rd !== exp.rd || act.value !== exp.value)))
    begin
      $display("[FAIL] %0t %s expected v=%0b rd=%0d val=%08h, actual v=%0b rd=%0d val=%08h",
               $time, sig, exp.valid, exp.rd, exp.value, act.valid, act.rd, act.value);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string sig, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("[FAIL] %0t %s expected %08h, actual %08h", $time, sig, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report(input string name, input int err_before);
    if (err_cnt == err_before)
    begin
      pass_cnt++;
      $display("test %s: ok", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: FAILED", name);
    end
  endtask

  function automatic logic pick_rdy(input bit stall_en);
    return stall_en ? ($urandom_range(3) != 0) : 1'b1;  // about one stall in four
  endfunction

  // reset and run the program while watching fetch and retire each cycle
  task automatic run_program(input bit stall_en);
    rv_pkg::retire_t last_rec;
    int              last_cycle;
    seen.delete();
    cycle      = 0;
    last_cycle = 4 * tests.size() + 12;
    rst_in     = 1'b1;
    rdy_in     = 1'b1;
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    check_addr("mem_a_o", 32'd0, mem_a);
    check_retire("retire_o", '0, retire);
    last_rec = retire;
    rdy_in   = pick_rdy(stall_en);
    while (cycle < last_cycle)
    begin
      @(negedge clk_in);
      if (rdy_in)
      begin
        cycle++;
        if (retire.valid)
        begin
          seen.push_back(retire);
        end
      end
      else
      begin
        check_retire("retire_o held", last_rec, retire);  // frozen cycle
      end
      check_addr("mem_a_o", 32'(cycle), mem_a);
      if (cycle <= 7)
      begin
        check_retire("retire_o", '0, retire);  // pipeline still filling
      end
      last_rec = retire;
      rdy_in   = pick_rdy(stall_en);
    end
  endtask

  // walk the table and the collected records side by side
  task automatic match_table(input bit per_test, output int used);
    int              err_before;
    rv_pkg::retire_t expected;
    used = 0;
    foreach (tests[i])
    begin
      err_before = err_cnt;
      if (tests[i].retires)
      begin
        if (used >= seen.size())
        begin
          $display("%0t: %s produced no retire record", $time, tests[i].name);
          err_cnt++;
        end
        else
        begin
          expected.valid = 1'b1;
          expected.rd    = tests[i].rd;
          expected.value = tests[i].value;
          check_retire("retire_o", expected, seen[used]);
          used++;
        end
      end
      if (per_test)
      begin
        report(tests[i].name, err_before);
      end
    end
  endtask

  task automatic check_count(input int used);
    if (seen.size() != used)
    begin
      $display("%0t: %0d retire records seen, the program allows only %0d",
               $time, seen.size(), used);
      err_cnt++;
    end
  endtask

  initial
  begin
    int used;
    int err_before;
    void'($urandom(32'h4d94f60d));
    rst_in = 1'b1;
    rdy_in = 1'b1;
    build_table();
    load_program();

    err_before = err_cnt;
    run_program(1'b0);
    report("fetch addressing", err_before);
    match_table(1'b1, used);
    err_before = err_cnt;
    check_count(used);
    report("retire count", err_before);

    // same program again with rdy_in dropping at random
    err_before = err_cnt;
    run_program(1'b1);
    report("stall hold", err_before);
    err_before = err_cnt;
    match_table(1'b0, used);
    check_count(used);
    report("stalled run sequence", err_before);

    $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog budget is four times the stall-free length of one run
  initial
  begin
    longint limit;
    #1;
    limit = (longint'(tests.size()) * 4 + 20) * 20 * 4;
    #(limit);
    $display("timeout: the runs did not finish within %0d ns", limit);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== flist.f ====
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/cpu.sv
tests/mem_model.sv
tests/tb_cpu.sv

// ==== Makefile ====
# Verilator build for the reduced RV32I core

TOP       ?= tb_cpu
VERILATOR ?= verilator
BUILD_DIR ?= build
SEED_ARGS ?=
FLIST     ?= flist.f

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass only if the testbench printed its pass message
run: compile
	@out="$$($(BIN) $(SEED_ARGS))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(BUILD_DIR)
